// File: hdl/jag_media_pkg.sv
// ========================================
// shared widths, constants and packed struct
// types for the media side of the console
// ========================================

package jag_media_pkg;

	// ========================================
	// constants
	// ========================================

	localparam logic [5:0]  CART_INDEX  = 6'd1;       // download index of a cart image
	localparam logic [23:0] CART_BASE   = 24'h80_0000; // byte address of cart start
	localparam int          BK_SECTORS  = 4;
	localparam int          BK_ADDR_W   = 10;
	localparam int          BK_DATA_W   = 16;
	localparam int          SECT_ADDR_W = 8;          // words per sector index
	localparam int          LBA_W       = BK_ADDR_W - SECT_ADDR_W;

	// ========================================
	// struct types
	// ========================================

	// host download stream
	typedef struct packed {
		logic        active;
		logic        wr;    // one cycle per word
		logic [5:0]  index;
		logic [15:0] data;
	} dl_stream_t;

	// one 64-bit write beat into cart memory
	typedef struct packed {
		logic [23:0] addr; // byte address
		logic [7:0]  be;   // one 16-bit lane set
		logic [63:0] data; // swapped word in all lanes
	} cart_beat_t;

	// menu levels
	typedef struct packed {
		logic load;
		logic save;
		logic autosave;
	} menu_cmd_t;

	// start pulses into the sequencer
	typedef struct packed {
		logic load;
		logic save;
	} bk_cmd_t;

	// core side of backup ram
	typedef struct packed {
		logic [BK_ADDR_W-1:0] addr;
		logic [BK_DATA_W-1:0] data;
		logic                 wr;
	} bram_port_t;

	// storage request to the host
	typedef struct packed {
		logic             rd;
		logic             wr;
		logic [LBA_W-1:0] lba;
	} sd_req_t;

	// host sector buffer write
	typedef struct packed {
		logic [SECT_ADDR_W-1:0] addr;
		logic [BK_DATA_W-1:0]   data;
		logic                   wr;
	} sd_buf_t;

endpackage

// File: hdl/cart_loader.sv
// ========================================
// download stream to cart write beats with
// four-phase memory handshake
// ========================================

`timescale 1ns/10ps

module cart_loader (
	input  logic                      clk_sys,
	input  logic                      reset,
	input  jag_media_pkg::dl_stream_t dl,
	output logic                      cart_active,
	output logic                      download_wait, // holds the stream off
	output jag_media_pkg::cart_beat_t cart_mem,
	output logic                      mem_req,
	input  logic                      mem_ack
);
	import jag_media_pkg::*;

	typedef enum logic [1:0] {
		ST_IDLE, // waiting for a stream word
		ST_REQ,  // req high until ack
		ST_DROP  // req low until ack falls
	} ld_state_t;

	ld_state_t   state;
	logic        old_active;
	logic        is_cart;
	logic [23:0] loader_addr; // byte address of the next beat
	logic [15:0] word_q;      // latched stream word
	logic [15:0] word_bs;
	logic [7:0]  lane_be;

	assign is_cart = (dl.index == CART_INDEX);
	assign word_bs = {word_q[7:0], word_q[15:8]}; // big endian memory

	// lane from word offset inside the 64-bit beat
	always_comb begin
		case (loader_addr[2:1])
			2'd0:    lane_be = 8'b1100_0000;
			2'd1:    lane_be = 8'b0011_0000;
			2'd2:    lane_be = 8'b0000_1100;
			default: lane_be = 8'b0000_0011;
		endcase
	end

	assign cart_mem = '{addr: loader_addr, be: lane_be, data: {4{word_bs}}};

	// ========================================
	// download tracking and address
	// ========================================

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			old_active  <= 1'b0;
			cart_active <= 1'b0;
			loader_addr <= CART_BASE;
		end else begin
			old_active <= dl.active;
			if (!old_active && dl.active && is_cart) begin
				cart_active <= 1'b1;
				loader_addr <= CART_BASE; // every image starts at the base
			end
			if (old_active && !dl.active)
				cart_active <= 1'b0;
			if (state == ST_REQ && mem_ack)
				loader_addr <= loader_addr + 24'd2; // one word per beat
		end
	end

	// payload, taken only while idle
	always_ff @(posedge clk_sys) begin
		if (state == ST_IDLE && dl.wr)
			word_q <= dl.data;
	end

	// ========================================
	// memory handshake
	// ========================================

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			state         <= ST_IDLE;
			mem_req       <= 1'b0;
			download_wait <= 1'b0;
		end else begin
			case (state)
				ST_IDLE: if (dl.wr && dl.active && is_cart) begin
					mem_req       <= 1'b1;
					download_wait <= 1'b1; // one beat in flight
					state         <= ST_REQ;
				end
				ST_REQ: if (mem_ack) begin
					mem_req <= 1'b0;
					state   <= ST_DROP;
				end
				ST_DROP: if (!mem_ack) begin
					download_wait <= 1'b0; // stream may go on
					state         <= ST_IDLE;
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

endmodule

// File: hdl/media_settings.sv
// ========================================
// backup enable, pending autosave flag and
// start pulses for the backup sequencer
// ========================================

`timescale 1ns/10ps

module media_settings (
	input  logic                     clk_sys,
	input  logic                     reset,
	input  jag_media_pkg::menu_cmd_t menu,
	input  logic                     cart_active,
	input  logic                     img_mounted,
	input  logic                     img_readonly,
	input  logic                     osd_open,
	input  logic                     core_wr,     // core writes backup ram
	input  logic                     backup_busy,
	output jag_media_pkg::bk_cmd_t   bk_cmd
);
	import jag_media_pkg::*;

	logic old_cart;      // cart_active one cycle back
	logic bk_ena;        // backup allowed
	logic pending;       // unsaved core writes
	logic auto_save;
	logic load_q, load_qq;
	logic save_q, save_qq;

	// autosave wants a save as soon as the menu opens
	assign auto_save = pending & menu.autosave & osd_open;

	// ========================================
	// enable and pending
	// ========================================

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			old_cart <= 1'b0;
			bk_ena   <= 1'b0;
			pending  <= 1'b0;
		end else begin
			old_cart <= cart_active;
			if (!old_cart && cart_active)
				bk_ena <= 1'b0; // new cart, old save invalid
			// save file is mounted during the download
			if (cart_active && img_mounted && !img_readonly)
				bk_ena <= 1'b1;

			if (bk_ena && !osd_open && core_wr)
				pending <= 1'b1;
			else if (backup_busy)
				pending <= 1'b0; // a transfer covers it
		end
	end

	// ========================================
	// command edges
	// ========================================

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			load_q  <= 1'b0;
			load_qq <= 1'b0;
			save_q  <= 1'b0;
			save_qq <= 1'b0;
			bk_cmd  <= '0;
		end else begin
			load_q  <= menu.load;             // register stage
			load_qq <= load_q;
			save_q  <= menu.save | auto_save;
			save_qq <= save_q;
			// menu load or the end of a cart download
			bk_cmd.load <= bk_ena & ((load_q & ~load_qq) | (old_cart & ~cart_active));
			bk_cmd.save <= bk_ena & save_q & ~save_qq;
		end
	end

endmodule

// File: hdl/backup_sequencer.sv
// ========================================
// four-sector backup load and save FSM over
// the host storage handshake
// ========================================

`timescale 1ns/10ps

module backup_sequencer (
	input  logic                   clk_sys,
	input  logic                   reset,
	input  jag_media_pkg::bk_cmd_t bk_cmd,
	output jag_media_pkg::sd_req_t sd_req,
	input  logic                   sd_ack,
	input  jag_media_pkg::sd_buf_t sd_buf,
	output logic                   backup_busy,
	output logic                   host_wr      // gated buffer write into ram
);
	import jag_media_pkg::*;

	localparam logic [LBA_W-1:0] LAST_LBA = LBA_W'(BK_SECTORS - 1);

	logic old_ack;
	logic loading;  // direction of the running transfer
	logic ack_rise;
	logic ack_fall;

	assign ack_rise = !old_ack && sd_ack;
	assign ack_fall = old_ack && !sd_ack; // sector done

	// ========================================
	// sector stepping
	// ========================================

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			old_ack     <= 1'b0;
			loading     <= 1'b0;
			backup_busy <= 1'b0;
			sd_req      <= '0;
		end else begin
			old_ack <= sd_ack;

			// host took the request
			if (ack_rise) begin
				sd_req.rd <= 1'b0;
				sd_req.wr <= 1'b0;
			end

			if (!backup_busy) begin
				// load wins when both arrive together
				if (bk_cmd.load || bk_cmd.save) begin
					backup_busy <= 1'b1;
					loading     <= bk_cmd.load;
					sd_req.lba  <= '0;
					sd_req.rd   <= bk_cmd.load;
					sd_req.wr   <= ~bk_cmd.load;
				end
			end else if (ack_fall) begin
				if (sd_req.lba == LAST_LBA) begin
					backup_busy <= 1'b0; // all sectors moved
					loading     <= 1'b0;
					sd_req.lba  <= '0;
				end else begin
					sd_req.lba <= sd_req.lba + 1'b1;
					sd_req.rd  <= loading;
					sd_req.wr  <= ~loading;
				end
			end
		end
	end

	// ========================================
	// buffer gating
	// ========================================

	// host data lands in ram only during a running load
	assign host_wr = backup_busy & loading & sd_ack & sd_buf.wr;

endmodule

// File: hdl/backup_ram.sv
// ========================================
// dual-port backup memory, 1024 x 16
// ========================================

`timescale 1ns/10ps

module backup_ram (
	input  logic                                  clk_sys,
	input  jag_media_pkg::bram_port_t             core_bram,
	output logic [jag_media_pkg::BK_DATA_W-1:0]   core_bram_q,
	input  logic [jag_media_pkg::BK_ADDR_W-1:0]   host_addr,   // lba with sector word
	input  logic [jag_media_pkg::BK_DATA_W-1:0]   host_data,
	input  logic                                  host_wr,
	output logic [jag_media_pkg::BK_DATA_W-1:0]   host_q
);
	import jag_media_pkg::*;

	logic [BK_DATA_W-1:0] mem [0:(1 << BK_ADDR_W)-1];

	// both ports in one block
	// a host write wins a same-address collision
	always_ff @(posedge clk_sys) begin
		if (core_bram.wr)
			mem[core_bram.addr] <= core_bram.data;
		if (host_wr)
			mem[host_addr] <= host_data;
	end

	// registered reads, one cycle after the address
	always_ff @(posedge clk_sys) begin
		core_bram_q <= mem[core_bram.addr];
		host_q      <= mem[host_addr];
	end

endmodule

// File: hdl/jag_media_top.sv
// ========================================
// media top, cart loader and backup path
// ========================================

`timescale 1ns/10ps

module jag_media_top (
	input  logic                                clk_sys,
	input  logic                                reset,
	input  jag_media_pkg::dl_stream_t           dl,
	output logic                                download_wait,
	output jag_media_pkg::cart_beat_t           cart_mem,
	output logic                                mem_req,
	input  logic                                mem_ack,
	input  jag_media_pkg::menu_cmd_t            menu,
	input  logic                                img_mounted,
	input  logic                                img_readonly,
	input  logic                                osd_open,
	input  jag_media_pkg::bram_port_t           core_bram,
	output logic [jag_media_pkg::BK_DATA_W-1:0] core_bram_q,
	output jag_media_pkg::sd_req_t              sd_req,
	input  logic                                sd_ack,
	input  jag_media_pkg::sd_buf_t              sd_buf,
	output logic [jag_media_pkg::BK_DATA_W-1:0] sd_buf_q,
	output logic                                backup_busy
);
	import jag_media_pkg::*;

	logic    cart_active; // cart download running
	bk_cmd_t bk_cmd;
	logic    host_wr;

	// cart download stream
	cart_loader u_cart_loader (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.dl            (dl),
		.cart_active   (cart_active),
		.download_wait (download_wait),
		.cart_mem      (cart_mem),
		.mem_req       (mem_req),
		.mem_ack       (mem_ack)
	);

	media_settings u_media_settings (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.menu         (menu),
		.cart_active  (cart_active),
		.img_mounted  (img_mounted),
		.img_readonly (img_readonly),
		.osd_open     (osd_open),
		.core_wr      (core_bram.wr),
		.backup_busy  (backup_busy),
		.bk_cmd       (bk_cmd)
	);

	backup_sequencer u_backup_sequencer (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.bk_cmd      (bk_cmd),
		.sd_req      (sd_req),
		.sd_ack      (sd_ack),
		.sd_buf      (sd_buf),
		.backup_busy (backup_busy),
		.host_wr     (host_wr)
	);

	// host port addressed by sector and word
	backup_ram u_backup_ram (
		.clk_sys     (clk_sys),
		.core_bram   (core_bram),
		.core_bram_q (core_bram_q),
		.host_addr   ({sd_req.lba, sd_buf.addr}),
		.host_data   (sd_buf.data),
		.host_wr     (host_wr),
		.host_q      (sd_buf_q)
	);

endmodule

// File: bench/tb_jag_media.sv
// ========================================
// testbench for the media top: memory and
// storage host models, directed tests
// ========================================

`timescale 1ns/10ps

module tb_jag_media;
	import jag_media_pkg::*;

	localparam logic [31:0] SEED = 32'h5392_1c3c;
	localparam int WORD_CYC = 24;        // worst case per stream word
	localparam int SECT_CYC = 256 + 24;  // worst case per sector
	localparam int TEST_CYC = 10 + (12 * WORD_CYC + 10) + 50
		+ (4 * WORD_CYC + 20 + 4 * SECT_CYC + 1030)
		+ (30 + 4 * SECT_CYC) + (70 + 4 * SECT_CYC);

	logic clk_sys, reset;
	dl_stream_t dl;
	logic download_wait;
	cart_beat_t cart_mem;
	logic mem_req, mem_ack;
	menu_cmd_t menu;
	logic img_mounted, img_readonly, osd_open;
	bram_port_t core_bram;
	logic [BK_DATA_W-1:0] core_bram_q, sd_buf_q;
	sd_req_t sd_req;
	logic sd_ack;
	sd_buf_t sd_buf;
	logic backup_busy;

	logic [31:0] lfsr_state;
	int errors, checks, tests;
	cart_beat_t beat_log[$];               // beats seen by the memory model
	sd_req_t req_log[$];                   // requests seen by the host model
	logic [BK_DATA_W-1:0] sect_data [0:1023];  // words the host loaded
	logic [BK_DATA_W-1:0] host_saved [0:1023]; // words the host read back

	jag_media_top dut (.*);

	initial begin
		clk_sys = 1'b0;
		forever #2 clk_sys = ~clk_sys;
	end

	// ========================================
	// random source and compare tasks
	// ========================================

	// galois lfsr, one step per bit
	function automatic logic [15:0] rand_bits(input int n);
		logic [15:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[14:0], lfsr_state[0]};
			lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h8020_0003) : (lfsr_state >> 1);
		end
		return v;
	endfunction

	task automatic compare_beat(input string name, input cart_beat_t got, input cart_beat_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic compare_req(input string name, input sd_req_t got, input sd_req_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic compare_word(input string name, input logic [15:0] got, input logic [15:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic compare_bit(input string name, input logic got, input logic exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("[FAIL] %0t %s got %b expected %b", $time, name, got, exp);
		end
	endtask

	// ========================================
	// memory and storage host models
	// ========================================

	initial begin : mem_model
		cart_beat_t held;
		forever begin
			@(negedge clk_sys);
			if (mem_req && !mem_ack) begin
				held = cart_mem;
				beat_log.push_back(held);
				repeat (rand_bits(3)) @(negedge clk_sys);
				compare_beat("cart_mem held under req", cart_mem, held);
				mem_ack = 1'b1;
				while (mem_req) @(negedge clk_sys);
				repeat (rand_bits(3)) @(negedge clk_sys);
				mem_ack = 1'b0;
			end
		end
	end

	initial begin : host_model
		sd_req_t cur;
		forever begin
			@(negedge clk_sys);
			if ((sd_req.rd || sd_req.wr) && !sd_ack) begin
				cur = sd_req;
				req_log.push_back(cur);
				repeat (rand_bits(3)) @(negedge clk_sys);
				sd_ack = 1'b1; // sector streams from here
				for (int i = 0; i < 256; i++) begin
					sd_buf.addr = i[7:0];
					if (cur.rd) begin
						sd_buf.data = rand_bits(16);
						sd_buf.wr   = 1'b1;
						sect_data[{cur.lba, i[7:0]}] = sd_buf.data;
					end
					@(negedge clk_sys);
					if (cur.wr)
						host_saved[{cur.lba, i[7:0]}] = sd_buf_q; // one cycle after addr
				end
				sd_buf.wr = 1'b0;
				repeat (rand_bits(3)) @(negedge clk_sys);
				if (sd_req.rd || sd_req.wr || sd_req.lba != cur.lba) begin
					errors++;
					$display("storage request not dropped or lba moved before ack fall");
				end
				sd_ack = 1'b0;
			end
		end
	end

	// ========================================
	// helpers
	// ========================================

	task automatic expect_idle();
		compare_bit("sd_req.rd", sd_req.rd, 1'b0);
		compare_bit("sd_req.wr", sd_req.wr, 1'b0);
		compare_bit("backup_busy", backup_busy, 1'b0);
	endtask

	task automatic wait_busy(input logic level, input int limit, input string what);
		int n;
		n = 0;
		while (backup_busy !== level && n < limit) begin
			@(negedge clk_sys);
			n++;
		end
		if (backup_busy !== level) begin
			errors++;
			$display("backup_busy never reached %b while waiting for %s", level, what);
		end
	endtask

	task automatic verify_requests(input logic rd);
		sd_req_t exp;
		if (req_log.size() != BK_SECTORS) begin
			errors++;
			$display("expected %0d storage requests but saw %0d", BK_SECTORS, req_log.size());
		end
		for (int i = 0; i < req_log.size() && i < BK_SECTORS; i++) begin
			exp = '{rd: rd, wr: ~rd, lba: i[LBA_W-1:0]};
			compare_req($sformatf("sd_req %0d", i), req_log[i], exp);
		end
	endtask

	task automatic end_test(input string name, input int err0);
		tests++;
		$display("%s finished with %0d errors", name, errors - err0);
	endtask

	// stream one cart image, check every beat
	task automatic stream_cart(input int words);
		logic [15:0] w;
		logic [23:0] a;
		int n;
		cart_beat_t exp_q[$];
		beat_log.delete();
		dl.index  = CART_INDEX;
		dl.active = 1'b1;
		@(negedge clk_sys);
		for (int k = 0; k < words; k++) begin
			w = rand_bits(16);
			a = CART_BASE + 24'(2 * k);
			exp_q.push_back('{addr: a, be: 8'hC0 >> {a[2:1], 1'b0}, data: {4{w[7:0], w[15:8]}}});
			dl.data = w;
			dl.wr   = 1'b1;
			@(negedge clk_sys);
			dl.wr = 1'b0;
			compare_bit("download_wait", download_wait, 1'b1);
			n = 0;
			while (download_wait && n < WORD_CYC) begin
				@(negedge clk_sys);
				n++;
			end
			if (download_wait) begin
				errors++;
				$display("download_wait stuck high after word %0d", k);
			end
		end
		dl.active = 1'b0;
		@(negedge clk_sys);
		if (beat_log.size() != words) begin
			errors++;
			$display("expected %0d cart beats but saw %0d", words, beat_log.size());
		end
		for (int k = 0; k < beat_log.size() && k < words; k++)
			compare_beat($sformatf("cart_mem beat %0d", k), beat_log[k], exp_q[k]);
	endtask

	// ========================================
	// directed tests
	// ========================================

	task automatic after_reset();
		int err0;
		err0 = errors;
		compare_bit("mem_req", mem_req, 1'b0);
		compare_bit("download_wait", download_wait, 1'b0);
		expect_idle();
		end_test("after_reset", err0);
	endtask

	task automatic cart_download();
		int err0;
		err0 = errors;
		img_mounted = 1'b0; // no save file yet
		stream_cart(12);
		end_test("cart_download", err0);
	endtask

	task automatic save_while_disabled();
		int err0;
		err0 = errors;
		menu.save = 1'b1;
		repeat (40) begin
			@(negedge clk_sys);
			expect_idle();
		end
		menu.save = 1'b0;
		end_test("save_while_disabled", err0);
	endtask

	task automatic autoload_after_download();
		int err0;
		err0 = errors;
		img_mounted = 1'b1;
		req_log.delete();
		stream_cart(4);
		wait_busy(1'b1, 10, "autoload start");
		wait_busy(1'b0, 4 * SECT_CYC, "autoload end");
		verify_requests(1'b1);
		for (int a = 0; a < 1024; a++) begin
			core_bram.addr = a[9:0];
			@(negedge clk_sys);
			compare_word($sformatf("core_bram_q[%0d]", a), core_bram_q, sect_data[a]);
		end
		end_test("autoload_after_download", err0);
	endtask

	task automatic menu_save();
		int err0;
		logic [9:0] addr [8];
		logic [15:0] data [8];
		logic [15:0] r;
		err0 = errors;
		req_log.delete();
		for (int k = 0; k < 8; k++) begin
			r = rand_bits(7);
			addr[k] = {k[2:0], r[6:0]}; // spread over all sectors
			data[k] = rand_bits(16);
			core_bram = '{addr: addr[k], data: data[k], wr: 1'b1};
			@(negedge clk_sys);
		end
		core_bram.wr = 1'b0;
		menu.save = 1'b1;
		wait_busy(1'b1, 10, "menu save start");
		wait_busy(1'b0, 4 * SECT_CYC, "menu save end");
		menu.save = 1'b0;
		verify_requests(1'b0);
		for (int k = 0; k < 8; k++)
			compare_word($sformatf("saved word %0d", addr[k]), host_saved[addr[k]], data[k]);
		end_test("menu_save", err0);
	endtask

	task automatic autosave_on_menu_open();
		int err0;
		logic [15:0] r;
		logic [15:0] d;
		err0 = errors;
		req_log.delete();
		menu.autosave = 1'b1;
		r = rand_bits(10);
		d = rand_bits(16);
		core_bram = '{addr: r[9:0], data: d, wr: 1'b1}; // menu closed, sets pending
		@(negedge clk_sys);
		core_bram.wr = 1'b0;
		osd_open = 1'b1;
		wait_busy(1'b1, 10, "autosave start");
		wait_busy(1'b0, 4 * SECT_CYC, "autosave end");
		verify_requests(1'b0);
		compare_word("autosaved word", host_saved[r[9:0]], d);
		osd_open = 1'b0;
		repeat (5) @(negedge clk_sys);
		osd_open = 1'b1; // pending already cleared
		repeat (40) begin
			@(negedge clk_sys);
			expect_idle();
		end
		osd_open = 1'b0;
		menu.autosave = 1'b0;
		end_test("autosave_on_menu_open", err0);
	endtask

	// ========================================
	// main sequence and watchdog
	// ========================================

	initial begin : main
		lfsr_state = SEED;
		errors = 0;
		checks = 0;
		tests = 0;
		reset = 1'b1;
		dl = '0;
		mem_ack = 1'b0;
		menu = '0;
		img_mounted = 1'b0;
		img_readonly = 1'b0;
		osd_open = 1'b0;
		core_bram = '0;
		sd_ack = 1'b0;
		sd_buf = '0;
		repeat (3) @(posedge clk_sys);
		@(negedge clk_sys);
		reset = 1'b0;
		after_reset();
		cart_download();
		save_while_disabled();
		autoload_after_download();
		menu_save();
		autosave_on_menu_open();
		$display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
		if (errors == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

	initial begin : watchdog
		repeat (2 * TEST_CYC) @(posedge clk_sys);
		$display("watchdog expired, run did not finish within %0d cycles", 2 * TEST_CYC);
		$display("Errors found");
		$finish;
	end

endmodule

// File: jag_media.f
hdl/jag_media_pkg.sv
hdl/cart_loader.sv
hdl/media_settings.sv
hdl/backup_sequencer.sv
hdl/backup_ram.sv
hdl/jag_media_top.sv
bench/tb_jag_media.sv

// File: Makefile
TOOL  = verilator
FLAGS = --binary --timing -Wno-fatal
TOP   = tb_jag_media
FLIST = jag_media.f
BUILD = obj_dir
SIM   = $(BUILD)/V$(TOP)
LOG   = sim.log
SRCS  = $(shell cat $(FLIST))

.PHONY: all run clean

all: run

$(SIM): $(SRCS) $(FLIST)
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	grep -q "^No errors$$" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
